// ==== rtl/controlPkg.sv ====
// Control unit shared types
`default_nettype none

package controlPkg;

    localparam int unsigned opcodeWidth = 6;
    localparam int unsigned aluOpWidth = 4;
    localparam int unsigned stepWidth = 3;

    // ALU codes the unit produces on its own
    localparam logic [aluOpWidth-1:0] aluPass = 4'd0;
    localparam logic [aluOpWidth-1:0] aluAdd = 4'd1;

    // execute step numbers
    localparam logic [stepWidth-1:0] stepFields = 3'd3;     // static fields load here
    localparam logic [stepWidth-1:0] stepHaltWait = 3'd3;   // HALT parks here until irq
    localparam logic [stepWidth-1:0] lastStepAlu = 3'd5;
    localparam logic [stepWidth-1:0] lastStepBranch = 3'd5;
    localparam logic [stepWidth-1:0] lastStepMem = 3'd6;
    localparam logic [stepWidth-1:0] lastStepNop = 3'd4;    // also HALT

    // instruction set encodings
    typedef enum logic [opcodeWidth-1:0] {
        opRType = 6'b000000,
        opAddi  = 6'b000001,
        opSubi  = 6'b000010,
        opAndi  = 6'b000011,
        opOri   = 6'b000100,
        opXori  = 6'b000101,
        opNoti  = 6'b000110,
        opSlai  = 6'b000111,
        opSrli  = 6'b001000,
        opSrai  = 6'b001001,
        opBr    = 6'b001010,
        opBmi   = 6'b001011,
        opBpl   = 6'b001100,
        opBz    = 6'b001101,
        opLd    = 6'b001110,
        opSt    = 6'b001111,
        opMove  = 6'b010010,
        opPush  = 6'b010011,   // stack ops are not supported
        opPop   = 6'b010100,
        opCall  = 6'b010101,
        opHalt  = 6'b010110,
        opNop   = 6'b010111,
        opRet   = 6'b011000,
        opNori  = 6'b011001,
        opSlti  = 6'b011010,
        opSgti  = 6'b011011
    } opcode_t;

    // what the sequencer needs to know about an opcode
    typedef enum logic [2:0] {
        clsAluReg = 3'd0,
        clsAluImm = 3'd1,
        clsBranch = 3'd2,
        clsLoad   = 3'd3,
        clsStore  = 3'd4,
        clsHalt   = 3'd5,
        clsNop    = 3'd6
    } instrClass_t;

    // branch condition seen by the PC logic
    typedef enum logic [2:0] {
        brNone   = 3'd0,
        brAlways = 3'd1,
        brPlus   = 3'd2,
        brMinus  = 3'd3,
        brZero   = 3'd4
    } branchKind_t;

    // fields that stay put for a whole instruction
    typedef struct packed {
        branchKind_t branchOp;
        logic [aluOpWidth-1:0] aluOp;
        logic aluSrc;      // 1 selects the immediate
        logic regDst;      // 1 selects rd
    } ctrlStatic_t;

    // one-step datapath pulses
    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic memToReg;
    } ctrlStrobe_t;

    typedef struct packed {
        ctrlStatic_t staticFields;
        ctrlStrobe_t strobes;
    } ctrlWord_t;

endpackage

`default_nettype wire

// ==== rtl/opcodeDecoder.sv ====
// Opcode decoder
`default_nettype none

module opcodeDecoder (
    input  logic clk,
    input  logic reset,
    input  logic [controlPkg::opcodeWidth-1:0] opcode,
    input  logic sample,
    input  logic loadFields,
    output controlPkg::instrClass_t instrClass,
    output controlPkg::ctrlStatic_t fields
);

    logic [controlPkg::opcodeWidth-1:0] opcodeReg;
    controlPkg::branchKind_t branchKind;
    logic isMove;

    // opcode latch, taken at the end of fetch
    always_ff @(posedge clk) begin
        if (reset) begin
            opcodeReg <= '0;
        end else if (sample) begin
            opcodeReg <= opcode;
        end
    end

    // classify the latched opcode
    always_comb begin
        instrClass = controlPkg::clsNop;
        branchKind = controlPkg::brNone;
        isMove = 1'b0;
        case (opcodeReg)
            controlPkg::opRType: instrClass = controlPkg::clsAluReg;
            controlPkg::opAddi, controlPkg::opSubi, controlPkg::opAndi,
            controlPkg::opOri, controlPkg::opXori, controlPkg::opNori,
            controlPkg::opNoti, controlPkg::opSlai, controlPkg::opSrli,
            controlPkg::opSrai, controlPkg::opSlti, controlPkg::opSgti: begin
                instrClass = controlPkg::clsAluImm;
            end
            controlPkg::opMove: begin
                instrClass = controlPkg::clsAluImm;
                isMove = 1'b1;   // rt = rs + 0
            end
            controlPkg::opBr: begin
                instrClass = controlPkg::clsBranch;
                branchKind = controlPkg::brAlways;
            end
            controlPkg::opBpl: begin
                instrClass = controlPkg::clsBranch;
                branchKind = controlPkg::brPlus;
            end
            controlPkg::opBmi: begin
                instrClass = controlPkg::clsBranch;
                branchKind = controlPkg::brMinus;
            end
            controlPkg::opBz: begin
                instrClass = controlPkg::clsBranch;
                branchKind = controlPkg::brZero;
            end
            controlPkg::opLd: instrClass = controlPkg::clsLoad;
            controlPkg::opSt: instrClass = controlPkg::clsStore;
            controlPkg::opHalt: instrClass = controlPkg::clsHalt;
            // stack ops fall through as NOP
            controlPkg::opPush, controlPkg::opPop, controlPkg::opCall,
            controlPkg::opRet, controlPkg::opNop: instrClass = controlPkg::clsNop;
            default: instrClass = controlPkg::clsNop;
        endcase
    end

    // static fields, reloaded once per instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            fields <= '0;
        end else if (loadFields) begin
            fields <= '0;   // halt, nop and anything unknown
            case (instrClass)
                controlPkg::clsAluReg: begin
                    fields.aluOp <= controlPkg::aluPass;   // ALU decodes funct itself
                    fields.regDst <= 1'b1;
                end
                controlPkg::clsAluImm: begin
                    // low opcode bits pick the ALU op
                    fields.aluOp <= isMove ? controlPkg::aluAdd
                                           : opcodeReg[controlPkg::aluOpWidth-1:0];
                    fields.aluSrc <= 1'b1;
                end
                controlPkg::clsBranch: begin
                    fields.branchOp <= branchKind;
                    fields.aluOp <= controlPkg::aluAdd;   // pc + imm
                    fields.aluSrc <= 1'b1;
                end
                controlPkg::clsLoad, controlPkg::clsStore: begin
                    fields.aluOp <= controlPkg::aluAdd;   // address = rs + imm
                    fields.aluSrc <= 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/stepSequencer.sv ====
// Fetch and execute step sequencer
`default_nettype none

module stepSequencer (
    input  logic clk,
    input  logic reset,
    input  logic irq,
    input  controlPkg::instrClass_t instrClass,
    output logic sample,
    output logic loadFields,
    output controlPkg::ctrlStrobe_t strobes,
    output logic updatePc
);

    typedef enum logic {
        phFetch,
        phExecute
    } phase_t;

    phase_t phase;
    phase_t nextPhase;
    logic [controlPkg::stepWidth-1:0] step;
    logic [controlPkg::stepWidth-1:0] nextStep;
    logic [controlPkg::stepWidth-1:0] lastStep;
    logic haltStall;
    controlPkg::ctrlStrobe_t strobesNext;

    // handshake to the decoder
    assign sample = (phase == phFetch);
    assign loadFields = (phase == phExecute) && (step == controlPkg::stepFields);

    // final step per class
    always_comb begin
        case (instrClass)
            controlPkg::clsAluReg, controlPkg::clsAluImm: lastStep = controlPkg::lastStepAlu;
            controlPkg::clsBranch: lastStep = controlPkg::lastStepBranch;
            controlPkg::clsLoad, controlPkg::clsStore: lastStep = controlPkg::lastStepMem;
            default: lastStep = controlPkg::lastStepNop;   // halt, nop
        endcase
    end

    // HALT holds at its wait step while irq is low
    assign haltStall = (phase == phExecute) && (instrClass == controlPkg::clsHalt)
                       && (step == controlPkg::stepHaltWait) && !irq;

    // next phase and step
    always_comb begin
        nextPhase = phase;
        nextStep = step;
        if (phase == phFetch) begin
            nextPhase = phExecute;
            nextStep = '0;
        end else if (haltStall) begin
            nextStep = step;
        end else if (step == lastStep) begin
            nextPhase = phFetch;   // instruction done
            nextStep = '0;
        end else begin
            nextStep = step + 3'd1;
        end
    end

    // strobes for the step being entered
    always_comb begin
        strobesNext = '0;
        if (nextPhase == phExecute) begin
            case (instrClass)
                controlPkg::clsAluReg, controlPkg::clsAluImm: begin
                    strobesNext.regWrite = (nextStep == controlPkg::lastStepAlu);
                end
                controlPkg::clsLoad: begin
                    // read first, then write back from memory
                    strobesNext.memRead = (nextStep == controlPkg::lastStepMem - 3'd1);
                    strobesNext.regWrite = (nextStep == controlPkg::lastStepMem);
                    strobesNext.memToReg = (nextStep == controlPkg::lastStepMem);
                end
                controlPkg::clsStore: begin
                    strobesNext.memWrite = (nextStep == controlPkg::lastStepMem);
                end
                default: ;   // branch, halt, nop
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= phFetch;
            step <= '0;
            strobes <= '0;
            updatePc <= 1'b0;
        end else begin
            phase <= nextPhase;
            step <= nextStep;
            strobes <= strobesNext;
            // one cycle, during the fetch after the last step
            updatePc <= (phase == phExecute) && (nextPhase == phFetch);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/controlUnit.sv ====
// Multicycle control unit top
`default_nettype none

module controlUnit (
    input  logic clk,
    input  logic reset,
    input  logic [controlPkg::opcodeWidth-1:0] opcode,
    input  logic irq,
    output controlPkg::ctrlWord_t ctrl,
    output logic updatePc
);

    logic sample;
    logic loadFields;
    controlPkg::instrClass_t instrClass;
    controlPkg::ctrlStatic_t staticFields;
    controlPkg::ctrlStrobe_t strobeBits;

    opcodeDecoder decoder (
        .clk        (clk),
        .reset      (reset),
        .opcode     (opcode),
        .sample     (sample),
        .loadFields (loadFields),
        .instrClass (instrClass),
        .fields     (staticFields)
    );

    stepSequencer sequencer (
        .clk        (clk),
        .reset      (reset),
        .irq        (irq),
        .instrClass (instrClass),
        .sample     (sample),
        .loadFields (loadFields),
        .strobes    (strobeBits),
        .updatePc   (updatePc)
    );

    // static part from the decoder, pulses from the sequencer
    assign ctrl = {staticFields, strobeBits};

endmodule

`default_nettype wire

// ==== dv/tbClock.sv ====
// Testbench clock and reset
`default_nettype none

module tbClock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int halfPeriod = 20;   // 40 ns period
    localparam int resetCycles = 2;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 reset = 1'b0;   // just after the edge, ahead of the stimulus
    end

endmodule

`default_nettype wire

// ==== dv/controlUnitTb.sv ====
// Control unit testbench
`default_nettype none

module controlUnitTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int instrCount = 400;
    localparam int pulseTimeout = 30;       // cycles
    localparam int resetTimeout = 10;
    localparam int resetCheckCycles = 5;    // fetch plus steps 0 to 3
    localparam int tableSize = 31;
    localparam logic [31:0] seed = 32'hb1c2_9a5b;

    // what one instruction should produce
    typedef struct packed {
        controlPkg::ctrlStatic_t fields;
        logic [7:0] spacing;      // pulse to pulse, before any HALT wait
        logic [7:0] regWrites;
        logic [7:0] memReads;
        logic [7:0] memWrites;
        logic [7:0] memToRegs;
    } expect_t;

    typedef struct packed {
        logic [controlPkg::opcodeWidth-1:0] opcode;
        logic [7:0] haltWait;
        expect_t want;
    } pending_t;

    logic clk;
    logic reset;
    logic [controlPkg::opcodeWidth-1:0] opcode;
    logic irq;
    controlPkg::ctrlWord_t ctrl;
    logic updatePc;

    logic [31:0] rngState = seed;
    int checkedCount = 0;
    pending_t pending[$];   // issued, not yet retired

    // monitor state, per instruction
    int cyclesSinceReset = 0;
    int cycles = 0;
    int regWriteSeen = 0;
    int memReadSeen = 0;
    int memWriteSeen = 0;
    int memToRegSeen = 0;
    int readAt = 0;
    int writeBackAt = 0;

    // all defined opcodes, then a few holes in the map
    logic [controlPkg::opcodeWidth-1:0] opcodeTable [tableSize] = '{
        controlPkg::opRType, controlPkg::opAddi, controlPkg::opSubi, controlPkg::opAndi,
        controlPkg::opOri, controlPkg::opXori, controlPkg::opNoti, controlPkg::opSlai,
        controlPkg::opSrli, controlPkg::opSrai, controlPkg::opBr, controlPkg::opBmi,
        controlPkg::opBpl, controlPkg::opBz, controlPkg::opLd, controlPkg::opSt,
        controlPkg::opMove, controlPkg::opPush, controlPkg::opPop, controlPkg::opCall,
        controlPkg::opHalt, controlPkg::opNop, controlPkg::opRet, controlPkg::opNori,
        controlPkg::opSlti, controlPkg::opSgti,
        6'h10, 6'h11, 6'h1c, 6'h2d, 6'h3f
    };

    tbClock clockGen (
        .clk   (clk),
        .reset (reset)
    );

    controlUnit DUT (
        .clk      (clk),
        .reset    (reset),
        .opcode   (opcode),
        .irq      (irq),
        .ctrl     (ctrl),
        .updatePc (updatePc)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] state);
        logic [31:0] x;
        x = state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // expected behavior of one opcode
    function automatic expect_t expectedFor(logic [controlPkg::opcodeWidth-1:0] op);
        expect_t r;
        r = '0;
        r.spacing = 8'd6;   // nop timing unless matched below
        case (op)
            controlPkg::opRType: begin
                r.fields.regDst = 1'b1;
                r.spacing = 8'd7;
                r.regWrites = 8'd1;
            end
            controlPkg::opAddi, controlPkg::opSubi, controlPkg::opAndi,
            controlPkg::opOri, controlPkg::opXori, controlPkg::opNori,
            controlPkg::opNoti, controlPkg::opSlai, controlPkg::opSrli,
            controlPkg::opSrai, controlPkg::opSlti, controlPkg::opSgti: begin
                r.fields.aluOp = op[controlPkg::aluOpWidth-1:0];
                r.fields.aluSrc = 1'b1;
                r.spacing = 8'd7;
                r.regWrites = 8'd1;
            end
            controlPkg::opMove: begin
                r.fields.aluOp = controlPkg::aluAdd;
                r.fields.aluSrc = 1'b1;
                r.spacing = 8'd7;
                r.regWrites = 8'd1;
            end
            controlPkg::opBr, controlPkg::opBpl, controlPkg::opBmi, controlPkg::opBz: begin
                r.fields.aluOp = controlPkg::aluAdd;
                r.fields.aluSrc = 1'b1;
                r.spacing = 8'd7;
                if (op == controlPkg::opBr) r.fields.branchOp = controlPkg::brAlways;
                if (op == controlPkg::opBpl) r.fields.branchOp = controlPkg::brPlus;
                if (op == controlPkg::opBmi) r.fields.branchOp = controlPkg::brMinus;
                if (op == controlPkg::opBz) r.fields.branchOp = controlPkg::brZero;
            end
            controlPkg::opLd: begin
                r.fields.aluOp = controlPkg::aluAdd;
                r.fields.aluSrc = 1'b1;
                r.spacing = 8'd8;
                r.memReads = 8'd1;
                r.regWrites = 8'd1;
                r.memToRegs = 8'd1;
            end
            controlPkg::opSt: begin
                r.fields.aluOp = controlPkg::aluAdd;
                r.fields.aluSrc = 1'b1;
                r.spacing = 8'd8;
                r.memWrites = 8'd1;
            end
            default: ;   // HALT, NOP, stack ops, holes
        endcase
        return r;
    endfunction

    task automatic abortRun(string reason);
        $display("ERROR: %s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(string testName, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %0h actual %0h", testName, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch in %s", testName);
        end
    endtask

    task automatic waitForReset();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (reset && waited < resetTimeout);
        if (reset) begin
            abortRun("reset was never released");
        end
    endtask

    // returns 2 ns into the fetch cycle that carries the pulse
    task automatic waitForUpdatePc();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (!updatePc && waited < pulseTimeout);
        if (!updatePc) begin
            abortRun("updatePc never came within the timeout");
        end
    endtask

    task automatic waitForChecks();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (checkedCount < instrCount && waited < pulseTimeout);
        if (checkedCount < instrCount) begin
            abortRun("the last instruction never retired");
        end
    endtask

    task automatic clearCounters();
        cycles = 0;
        regWriteSeen = 0;
        memReadSeen = 0;
        memWriteSeen = 0;
        memToRegSeen = 0;
        readAt = 0;
        writeBackAt = 0;
    endtask

    // compare one retired instruction with its expected record
    task automatic closeInstruction();
        pending_t entry;
        string name;
        if (pending.size() == 0) begin
            abortRun("updatePc pulsed with no instruction outstanding");
        end
        entry = pending.pop_front();
        name = $sformatf("opcode %02h", entry.opcode);
        checkValue({name, " fields"}, 32'(entry.want.fields), 32'(ctrl.staticFields));
        checkValue({name, " spacing"}, 32'(entry.want.spacing) + 32'(entry.haltWait),
                   32'(cycles));
        checkValue({name, " regWrite"}, 32'(entry.want.regWrites), 32'(regWriteSeen));
        checkValue({name, " memRead"}, 32'(entry.want.memReads), 32'(memReadSeen));
        checkValue({name, " memWrite"}, 32'(entry.want.memWrites), 32'(memWriteSeen));
        checkValue({name, " memToReg"}, 32'(entry.want.memToRegs), 32'(memToRegSeen));
        if (entry.want.memToRegs != 8'd0) begin
            // write back follows the read directly
            checkValue({name, " read to writeback"}, 32'd1, 32'(writeBackAt - readAt));
        end
        checkedCount++;
    endtask

    // sample mid-cycle, away from the drive edge
    always @(negedge clk) begin
        if (!reset) begin
            cyclesSinceReset++;
            if (cyclesSinceReset <= resetCheckCycles) begin
                checkValue("reset ctrl", 32'd0, 32'(ctrl));
                checkValue("reset updatePc", 32'd0, 32'(updatePc));
            end
            if (updatePc) begin
                closeInstruction();
                clearCounters();
            end
            cycles++;   // the fetch cycle counts too
            if (ctrl.strobes.regWrite) regWriteSeen++;
            if (ctrl.strobes.memRead) memReadSeen++;
            if (ctrl.strobes.memWrite) memWriteSeen++;
            if (ctrl.strobes.memToReg) memToRegSeen++;
            if (ctrl.strobes.memRead) readAt = cycles;
            if (ctrl.strobes.regWrite && ctrl.strobes.memToReg) writeBackAt = cycles;
        end
    end

    initial begin
        logic [4:0] pick;
        logic [controlPkg::opcodeWidth-1:0] op;
        pending_t entry;
        opcode = controlPkg::opNop;
        irq = 1'b1;
        waitForReset();
        for (int n = 0; n < instrCount; n++) begin
            if (n > 0) begin
                waitForUpdatePc();
            end
            rngState = xorshift32(rngState);
            pick = 5'(rngState % tableSize);
            op = opcodeTable[pick];
            entry.opcode = op;
            entry.haltWait = 8'd0;
            if (op == controlPkg::opHalt) begin
                rngState = xorshift32(rngState);
                entry.haltWait = 8'(rngState % 32'd6);
            end
            entry.want = expectedFor(op);
            pending.push_back(entry);
            opcode = op;   // sampled at the end of this fetch cycle
            if (op == controlPkg::opHalt) begin
                irq = 1'b0;
                // fetch and steps 0 to 2, then the stall at step 3
                repeat (4 + int'(entry.haltWait)) @(posedge clk);
                #2;
                irq = 1'b1;
            end
        end
        waitForChecks();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/controlPkg.sv
rtl/opcodeDecoder.sv
rtl/stepSequencer.sv
rtl/controlUnit.sv
dv/tbClock.sv
dv/controlUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found on PATH"
    exit 1
fi

if ! verilator --binary --timing -f list.f --top-module controlUnitTb \
        --Mdir obj_dir -o controlUnitSim; then
    echo "verilator build failed"
    exit 1
fi

simOutput=$(./obj_dir/controlUnitSim 2>&1)
simStatus=$?
printf '%s\n' "$simOutput"

if [ "$simStatus" -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOutput" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
